/* vlog.f */
+incdir+rtl
rtl/cache_pkg.sv
rtl/cache_sram.sv
rtl/cache_ways.sv
rtl/cache_lookup.sv
rtl/cache_refill.sv
rtl/cache_top.sv
sim/cache_props.sv
sim/tb_cache.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the cache testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_cache -o tb_cache

out=$(./obj_dir/tb_cache 2>&1) || true
echo "$out"

if echo "$out" | grep -q "^PASS: all tests$"; then
    exit 0
fi
exit 1

/* sim/tb_cache.sv */
`timescale 1ns/1ps

module tb_cache;

    import cache_pkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int N_RANDOM   = 300;
    // directed accesses, random accesses and the final sweep
    localparam int N_OPS      = 17 + N_RANDOM + 32;
    localparam int MAX_WAIT   = 1000;

    typedef struct packed {
        logic  is_load;
        word_t data;
    } expect_t;

    logic        clk = 1'b0;
    logic        resetn;
    logic        valid;
    logic        op;
    logic [7:0]  index;
    logic [19:0] tag;
    logic [3:0]  offset;
    logic [3:0]  wstrb;
    word_t       wdata;
    logic        addr_ok;
    logic        data_ok;
    word_t       rdata;
    logic        rd_req;
    logic [31:0] rd_addr;
    logic        rd_rdy = 1'b0;
    logic        ret_valid = 1'b0;
    logic        ret_last = 1'b0;
    word_t       ret_data = '0;
    logic        wr_req;
    logic [31:0] wr_addr;
    line_t       wr_data;
    logic        wr_rdy = 1'b0;

    integer      seed = 32'hb376;
    int          errors = 0;
    int          checks = 0;
    int          wb_count = 0;
    int          beats_left = 0;
    logic [31:0] beat_addr = '0;
    logic [31:0] last_rd_addr = '0;
    word_t       mem [logic [31:0]];
    word_t       golden [logic [31:0]];
    // lines with a store since their last write-back
    bit          dirty_lines [logic [31:0]];
    expect_t     exp_q [$];
    // two sets and four tags, so lines fight for the two ways
    logic [19:0] tags [4] = '{20'h00010, 20'h00a21, 20'h3f002, 20'hfffff};
    logic [7:0]  idxs [2] = '{8'h03, 8'h7c};

    cache_top i_cache_top (.*);

    bind cache_top cache_props i_cache_props (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // backing memory contents before any write-back
    function automatic word_t init_word(logic [31:0] addr);
        return (addr * 32'h9e3779b1) ^ {addr[15:0], addr[31:16]};
    endfunction

    function automatic word_t mem_read(logic [31:0] addr);
        return mem.exists(addr) ? mem[addr] : init_word(addr);
    endfunction

    function automatic logic [31:0] make_addr(logic [1:0] t, logic i, logic [1:0] w);
        return {tags[t], idxs[i], w, 2'b00};
    endfunction

    // golden word after this access with all earlier stores applied
    function automatic word_t exp_word(logic st, logic [31:0] addr, logic [3:0] strb,
                                       word_t data);
        word_t w;
        word_t mask;
        w    = golden.exists(addr) ? golden[addr] : init_word(addr);
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        if (st) begin
            w = (w & ~mask) | (data & mask);
            golden[addr] = w;
        end
        return w;
    endfunction

    task automatic check(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic report_error(string what);
        errors++;
        $display("Error: %s", what);
    endtask

    task automatic report_test(string name, int err0);
        if (errors == err0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - err0);
        end
    endtask

    // issue one request and count cycles from accept to data_ok
    task automatic access(logic st, logic [31:0] addr, logic [3:0] strb, word_t data,
                          output int lat);
        int      waited;
        expect_t e;
        @(posedge clk);
        #1;
        valid  = 1'b1;
        op     = st;
        index  = addr[11:4];
        tag    = addr[31:12];
        offset = addr[3:0];
        wstrb  = strb;
        wdata  = data;
        waited = 0;
        lat    = 0;
        @(negedge clk);
        while (!addr_ok && waited < MAX_WAIT) begin
            waited++;
            @(negedge clk);
        end
        if (!addr_ok) begin
            report_error($sformatf("request to %h was never accepted", addr));
        end else begin
            e.is_load = !st;
            e.data    = exp_word(st, addr, strb, data);
            exp_q.push_back(e);
            if (st) begin
                dirty_lines[{addr[31:4], 4'h0}] = 1'b1;
            end
            @(posedge clk);
            #1;
            valid = 1'b0;
            lat   = 1;
            @(negedge clk);
            while (!data_ok && lat < MAX_WAIT) begin
                lat++;
                @(negedge clk);
            end
            if (!data_ok) begin
                report_error($sformatf("no data_ok for request to %h", addr));
            end
        end
    endtask

    // compare each answer against the queued expectation
    always @(negedge clk) begin : compare
        expect_t e;
        if (resetn && data_ok) begin
            if (exp_q.size() == 0) begin
                report_error("data_ok without an outstanding request");
            end else begin
                e = exp_q.pop_front();
                if (e.is_load) begin
                    check("rdata", rdata, e.data);
                end
            end
        end
    end

    // memory responder samples at negedge and drives 1 ns after the rising edge
    always begin : mem_model
        logic [127:0] flat;
        logic [31:0]  a;
        logic [31:0]  rnd;
        @(negedge clk);
        if (resetn && rd_req && rd_rdy) begin
            last_rd_addr = rd_addr;
            beat_addr    = rd_addr;
            beats_left   = 4;
        end
        if (resetn && wr_req) begin
            wb_count++;
            flat = wr_data;
            if (!dirty_lines.exists(wr_addr)) begin
                report_error($sformatf("write-back to %h, a line with no pending store",
                                       wr_addr));
            end else begin
                dirty_lines.delete(wr_addr);
            end
            for (int w = 0; w < 4; w++) begin
                a = wr_addr + 32'(4 * w);
                check($sformatf("wr_data[%0d]", w), flat[31:0], exp_word(1'b0, a, 4'h0, '0));
                mem[a] = flat[31:0];
                flat   = flat >> 32;
            end
        end
        @(posedge clk);
        #1;
        rnd    = $random(seed);
        rd_rdy = rnd[0];
        wr_rdy = rnd[1];
        if (beats_left > 0 && rnd[3:2] != 2'b00) begin
            ret_valid  = 1'b1;
            ret_last   = (beats_left == 1);
            ret_data   = mem_read(beat_addr);
            beat_addr  = beat_addr + 32'd4;
            beats_left = beats_left - 1;
        end else begin
            ret_valid = 1'b0;
            ret_last  = 1'b0;
        end
    end

    initial begin : watchdog
        #(N_OPS * 200 * CLK_PERIOD);
        $display("Error: simulation timed out after %0d cycles", N_OPS * 200);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin : stimulus
        int          lat;
        int          err0;
        int          wb0;
        logic [31:0] rnd;
        logic [31:0] a;
        valid  = 1'b0;
        op     = 1'b0;
        index  = '0;
        tag    = '0;
        offset = '0;
        wstrb  = '0;
        wdata  = '0;
        resetn = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        resetn = 1'b1;

        err0 = errors;
        repeat (2) begin
            @(negedge clk);
            check("addr_ok", 32'(addr_ok), 32'h0);
            check("data_ok", 32'(data_ok), 32'h0);
            check("rd_req", 32'(rd_req), 32'h0);
            check("wr_req", 32'(wr_req), 32'h0);
        end
        report_test("reset state", err0);

        err0 = errors;
        a = make_addr(2'd0, 1'b0, 2'd1);
        access(1'b0, a, 4'h0, '0, lat);
        if (lat < 2) begin
            report_error("first load to a line did not miss");
        end
        check("rd_addr", last_rd_addr, {a[31:4], 4'h0});
        access(1'b0, make_addr(2'd0, 1'b0, 2'd2), 4'h0, '0, lat);
        check("load hit latency", lat, 32'd1);
        report_test("load miss then hit", err0);

        err0 = errors;
        access(1'b1, a, 4'b0110, 32'hdeadbeef, lat);
        check("store hit latency", lat, 32'd1);
        access(1'b0, a, 4'h0, '0, lat);
        check("load hit latency", lat, 32'd1);
        report_test("store hit", err0);

        err0 = errors;
        a = make_addr(2'd1, 1'b0, 2'd3);
        access(1'b1, a, 4'b1001, 32'h12345678, lat);
        if (lat < 2) begin
            report_error("store to a new line did not miss");
        end
        check("rd_addr", last_rd_addr, {a[31:4], 4'h0});
        for (int w = 0; w < 4; w++) begin
            access(1'b0, make_addr(2'd1, 1'b0, 2'(w)), 4'h0, '0, lat);
            check("load hit latency", lat, 32'd1);
        end
        report_test("store miss", err0);

        err0 = errors;
        wb0  = wb_count;
        for (int t = 0; t < 4; t++) begin
            access(1'b1, make_addr(2'(t), 1'b1, 2'd0), 4'hf, $random(seed), lat);
        end
        for (int t = 0; t < 4; t++) begin
            access(1'b0, make_addr(2'(t), 1'b1, 2'd0), 4'h0, '0, lat);
        end
        if (wb_count == wb0) begin
            report_error("no dirty line was written back");
        end
        report_test("dirty eviction", err0);

        err0 = errors;
        for (int n = 0; n < N_RANDOM; n++) begin
            rnd = $random(seed);
            a   = make_addr(rnd[1:0], rnd[2], rnd[4:3]);
            access(rnd[5], a, rnd[9:6], $random(seed), lat);
        end
        // final sweep over every word in use
        for (int t = 0; t < 4; t++) begin
            for (int i = 0; i < 2; i++) begin
                for (int w = 0; w < 4; w++) begin
                    access(1'b0, make_addr(2'(t), 1'(i), 2'(w)), 4'h0, '0, lat);
                end
            end
        end
        report_test("random traffic", err0);

        repeat (2) @(posedge clk);
        $display("tests: 6, checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, i_cache_top.i_cache_props.fail_count);
        if (errors == 0 && i_cache_top.i_cache_props.fail_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* sim/cache_props.sv */
`timescale 1ns/1ps

module cache_props (
    input logic clk,
    input logic resetn,
    input logic valid,
    input logic addr_ok,
    input logic data_ok,
    input logic rd_req,
    input logic rd_rdy,
    input logic wr_req,
    input logic wr_rdy
);

    int n_wr = 0;
    int n_rd = 0;
    int n_addr = 0;
    int n_data = 0;
    int fail_count;

    assign fail_count = n_wr + n_rd + n_addr + n_data;

    // write-back fires only in a ready cycle
    a_wr_rdy: assert property (@(posedge clk) disable iff (!resetn) wr_req |-> wr_rdy)
        else begin
            n_wr = n_wr + 1;
            $error("wr_req seen while wr_rdy is low");
        end

    a_rd_hold: assert property (@(posedge clk) disable iff (!resetn)
        rd_req && !rd_rdy |=> rd_req)
        else begin
            n_rd = n_rd + 1;
            $error("rd_req dropped before rd_rdy");
        end

    // no accept while the refill side is on the bus
    a_addr_ok: assert property (@(posedge clk) disable iff (!resetn)
        addr_ok |-> valid && !rd_req && !wr_req)
        else begin
            n_addr = n_addr + 1;
            $error("addr_ok without valid or during a line transfer");
        end

    // an answer never overlaps a pending line read
    a_data_rd: assert property (@(posedge clk) disable iff (!resetn) !(data_ok && rd_req))
        else begin
            n_data = n_data + 1;
            $error("data_ok together with rd_req");
        end

endmodule

/* rtl/cache_top.sv */
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_top (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       valid,
    input  logic                       op,
    input  logic [`CACHE_INDEX_W-1:0]  index,
    input  logic [`CACHE_TAG_W-1:0]    tag,
    input  logic [`CACHE_OFFSET_W-1:0] offset,
    input  logic [3:0]                 wstrb,
    input  cache_pkg::word_t           wdata,
    output logic                       addr_ok,
    output logic                       data_ok,
    output cache_pkg::word_t           rdata,
    output logic                       rd_req,
    output logic [31:0]                rd_addr,
    input  logic                       rd_rdy,
    input  logic                       ret_valid,
    input  logic                       ret_last,
    input  cache_pkg::word_t           ret_data,
    output logic                       wr_req,
    output logic [31:0]                wr_addr,
    output cache_pkg::line_t           wr_data,
    input  logic                       wr_rdy
);

    import cache_pkg::*;

    logic [`CACHE_INDEX_W-1:0] rd_index;
    way_rd_t                   way0_rd;
    way_rd_t                   way1_rd;
    logic [1:0]                dirty;
    way_wr_t                   hit_wr;
    way_wr_t                   fill_wr;
    logic                      miss_valid;
    miss_req_t                 miss_req;
    logic                      fill_done;
    logic                      hit_data_ok;
    logic                      fill_data_ok;
    word_t                     hit_rdata;
    word_t                     fill_rdata;

    cache_lookup i_cache_lookup (
        .clk, .resetn, .valid, .op, .index, .tag, .offset, .wstrb, .wdata,
        .addr_ok, .rd_index, .way0_rd, .way1_rd, .dirty, .hit_wr,
        .miss_valid, .miss_req, .fill_done, .hit_data_ok, .hit_rdata
    );

    cache_ways i_cache_ways (
        .clk, .resetn, .rd_index, .hit_wr, .fill_wr, .way0_rd, .way1_rd, .dirty
    );

    cache_refill i_cache_refill (
        .clk, .resetn, .miss_valid, .miss_req, .rd_req, .rd_addr, .rd_rdy,
        .ret_valid, .ret_last, .ret_data, .wr_req, .wr_addr, .wr_data, .wr_rdy,
        .fill_wr, .fill_done, .fill_data_ok, .fill_rdata
    );

    // hit and fill answers never overlap
    assign data_ok = hit_data_ok | fill_data_ok;
    assign rdata   = hit_rdata | fill_rdata;

endmodule

/* rtl/cache_refill.sv */
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_refill (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 miss_valid,
    input  cache_pkg::miss_req_t miss_req,
    output logic                 rd_req,
    output logic [31:0]          rd_addr,
    input  logic                 rd_rdy,
    input  logic                 ret_valid,
    input  logic                 ret_last,
    input  cache_pkg::word_t     ret_data,
    output logic                 wr_req,
    output logic [31:0]          wr_addr,
    output cache_pkg::line_t     wr_data,
    input  logic                 wr_rdy,
    output cache_pkg::way_wr_t   fill_wr,
    output logic                 fill_done,
    output logic                 fill_data_ok,
    output cache_pkg::word_t     fill_rdata
);

    import cache_pkg::*;

    localparam int WSEL_W = $clog2(`CACHE_WORDS);

    refill_state_t     state;
    refill_state_t     state_nxt;
    miss_req_t         miss_q;
    line_t             miss_buf;
    line_t             fill_line;
    logic [WSEL_W-1:0] beat;
    logic [WSEL_W-1:0] req_word;
    logic              need_wb;
    logic              fill_last;
    word_t             beat_word;

    always_ff @(posedge clk) begin
        if (miss_valid && (state == RF_IDLE)) begin
            miss_q <= miss_req;
        end
    end

    assign need_wb  = miss_q.dirty && miss_q.tagv.valid;
    assign req_word = miss_q.req.offset[2 +: WSEL_W];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= RF_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            RF_IDLE:    if (miss_valid) state_nxt = RF_MISS;
            RF_MISS:    if (!need_wb || wr_rdy) state_nxt = RF_REPLACE;
            RF_REPLACE: if (rd_rdy) state_nxt = RF_REFILL;
            RF_REFILL:  if (ret_valid && ret_last) state_nxt = RF_IDLE;
            default:    state_nxt = RF_IDLE;
        endcase
    end

    // dirty victim goes out in one beat
    assign wr_req  = (state == RF_MISS) && need_wb && wr_rdy;
    assign wr_addr = {miss_q.tagv.tag, miss_q.req.index, `CACHE_OFFSET_W'(0)};
    assign wr_data = miss_q.line;

    assign rd_req  = (state == RF_REPLACE);
    assign rd_addr = {miss_q.req.tag, miss_q.req.index, `CACHE_OFFSET_W'(0)};

    // return beat counter
    always_ff @(posedge clk) begin
        if (!resetn) begin
            beat <= '0;
        end else if (state != RF_REFILL) begin
            beat <= '0;
        end else if (ret_valid) begin
            beat <= beat + WSEL_W'(1);
        end
    end

    // a store miss takes its bytes in place of the returned ones
    assign beat_word = (miss_q.req.op && (beat == req_word))
                     ? merge_word(ret_data, miss_q.req.wdata, miss_q.req.wstrb)
                     : ret_data;

    always_ff @(posedge clk) begin
        if ((state == RF_REFILL) && ret_valid) begin
            miss_buf[beat] <= beat_word;
        end
    end

    // last beat is not in the buffer yet
    always_comb begin
        fill_line       = miss_buf;
        fill_line[beat] = beat_word;
    end

    assign fill_last = (state == RF_REFILL) && ret_valid && ret_last;

    assign fill_wr = '{we: fill_last, way: miss_q.way, index: miss_q.req.index,
                       tagv: '{tag: miss_q.req.tag, valid: 1'b1}, line: fill_line,
                       dirty: miss_q.req.op};

    assign fill_done    = fill_last;
    assign fill_data_ok = fill_last;
    assign fill_rdata   = fill_last ? fill_line[req_word] : '0;

endmodule

/* rtl/cache_lookup.sv */
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_lookup (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       valid,
    input  logic                       op,
    input  logic [`CACHE_INDEX_W-1:0]  index,
    input  logic [`CACHE_TAG_W-1:0]    tag,
    input  logic [`CACHE_OFFSET_W-1:0] offset,
    input  logic [3:0]                 wstrb,
    input  cache_pkg::word_t           wdata,
    output logic                       addr_ok,
    output logic [`CACHE_INDEX_W-1:0]  rd_index,
    input  cache_pkg::way_rd_t         way0_rd,
    input  cache_pkg::way_rd_t         way1_rd,
    input  logic [1:0]                 dirty,
    output cache_pkg::way_wr_t         hit_wr,
    output logic                       miss_valid,
    output cache_pkg::miss_req_t       miss_req,
    input  logic                       fill_done,
    output logic                       hit_data_ok,
    output cache_pkg::word_t           hit_rdata
);

    import cache_pkg::*;

    localparam int WSEL_W = $clog2(`CACHE_WORDS);

    lookup_state_t     state;
    lookup_state_t     state_nxt;
    cpu_req_t          req_q;
    logic [15:0]       lfsr;
    logic              accept;
    logic              hit0;
    logic              hit1;
    logic              hit;
    logic              victim;
    way_rd_t           victim_rd;
    logic [WSEL_W-1:0] word_sel;
    line_t             hit_line;
    line_t             merged_line;

    assign accept  = valid && (state == LK_IDLE);
    assign addr_ok = accept;

    // RAMs are read with the incoming index so tags are ready in LOOKUP
    assign rd_index = (state == LK_IDLE) ? index : req_q.index;

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= '{op: op, index: index, tag: tag, offset: offset,
                       wstrb: wstrb, wdata: wdata};
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= LK_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            LK_IDLE: begin
                if (accept) begin
                    state_nxt = LK_LOOKUP;
                end
            end
            LK_LOOKUP: begin
                state_nxt = hit ? LK_IDLE : LK_WAIT_FILL;
            end
            LK_WAIT_FILL: begin
                if (fill_done) begin
                    state_nxt = LK_IDLE;
                end
            end
            default: begin
                state_nxt = LK_IDLE;
            end
        endcase
    end

    // fibonacci LFSR, runs every cycle
    always_ff @(posedge clk) begin
        if (!resetn) begin
            lfsr <= `CACHE_LFSR_SEED;
        end else begin
            lfsr <= {lfsr[14:0], lfsr[10] ^ lfsr[12] ^ lfsr[13] ^ lfsr[15]};
        end
    end

    // tag compare
    assign hit0 = way0_rd.tagv.valid && (way0_rd.tagv.tag == req_q.tag);
    assign hit1 = way1_rd.tagv.valid && (way1_rd.tagv.tag == req_q.tag);
    assign hit  = hit0 || hit1;

    assign word_sel = req_q.offset[2 +: WSEL_W];
    assign hit_line = hit1 ? way1_rd.line : way0_rd.line;

    always_comb begin
        merged_line           = hit_line;
        merged_line[word_sel] = merge_word(hit_line[word_sel], req_q.wdata, req_q.wstrb);
    end

    assign hit_data_ok = (state == LK_LOOKUP) && hit;
    assign hit_rdata   = hit_data_ok ? hit_line[word_sel] : '0;

    // store hit rewrites the whole line at the end of LOOKUP
    assign hit_wr = '{we: hit_data_ok && req_q.op, way: hit1, index: req_q.index,
                      tagv: hit1 ? way1_rd.tagv : way0_rd.tagv, line: merged_line,
                      dirty: 1'b1};

    // victim way
    assign victim     = lfsr[0];
    assign victim_rd  = victim ? way1_rd : way0_rd;
    assign miss_valid = (state == LK_LOOKUP) && !hit;
    assign miss_req   = '{req: req_q, way: victim, tagv: victim_rd.tagv,
                          dirty: dirty[victim], line: victim_rd.line};

endmodule

/* rtl/cache_ways.sv */
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_ways (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic [`CACHE_INDEX_W-1:0] rd_index,
    input  cache_pkg::way_wr_t        hit_wr,
    input  cache_pkg::way_wr_t        fill_wr,
    output cache_pkg::way_rd_t        way0_rd,
    output cache_pkg::way_rd_t        way1_rd,
    output logic [1:0]                dirty
);

    import cache_pkg::*;

    localparam int SETS = 1 << `CACHE_INDEX_W;

    way_wr_t                   wr_sel;
    logic [`CACHE_INDEX_W-1:0] ram_addr;
    way_rd_t                   way_rd [2];

    // refill has priority, lookup never writes while a fill is pending
    assign wr_sel   = fill_wr.we ? fill_wr : hit_wr;
    assign ram_addr = wr_sel.we ? wr_sel.index : rd_index;

    for (genvar w = 0; w < 2; w++) begin : g_way
        logic            way_we;
        tagv_t           tag_rd;
        line_t           line_rd;
        logic [SETS-1:0] valid_vec;
        logic [SETS-1:0] dirty_vec;
        logic            valid_q;
        logic            dirty_q;

        assign way_we = wr_sel.we && (wr_sel.way == 1'(w));

        cache_sram #(.entry_t(tagv_t)) i_tag_ram (
            .clk   (clk),
            .we    (way_we),
            .addr  (ram_addr),
            .wdata (wr_sel.tagv),
            .rdata (tag_rd)
        );

        cache_sram #(.entry_t(line_t)) i_line_ram (
            .clk   (clk),
            .we    (way_we),
            .addr  (ram_addr),
            .wdata (wr_sel.line),
            .rdata (line_rd)
        );

        // valid and dirty live in flops so reset can clear them
        always_ff @(posedge clk) begin
            if (!resetn) begin
                valid_vec <= '0;
                dirty_vec <= '0;
                valid_q   <= 1'b0;
                dirty_q   <= 1'b0;
            end else begin
                if (way_we) begin
                    valid_vec[ram_addr] <= wr_sel.tagv.valid;
                    dirty_vec[ram_addr] <= wr_sel.dirty;
                end
                valid_q <= valid_vec[ram_addr];
                dirty_q <= dirty_vec[ram_addr];
            end
        end

        assign way_rd[w] = '{tagv: '{tag: tag_rd.tag, valid: tag_rd.valid && valid_q},
                             line: line_rd};
        assign dirty[w]  = dirty_q;
    end

    assign way0_rd = way_rd[0];
    assign way1_rd = way_rd[1];

endmodule

/* rtl/cache_sram.sv */
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_sram #(
    parameter type entry_t = logic [31:0]
) (
    input  logic                      clk,
    input  logic                      we,
    input  logic [`CACHE_INDEX_W-1:0] addr,
    input  entry_t                    wdata,
    output entry_t                    rdata
);

    localparam int DEPTH = 1 << `CACHE_INDEX_W;

    entry_t mem [DEPTH];

    // read-first: a write shows up on the next read of that entry
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

/* rtl/cache_pkg.sv */
`include "cache_settings.svh"

package cache_pkg;

    typedef logic [31:0] word_t;

    // word 0 sits in the low bits
    typedef word_t [`CACHE_WORDS-1:0] line_t;

    typedef struct packed {
        logic [`CACHE_TAG_W-1:0] tag;
        logic                    valid;
    } tagv_t;

    typedef struct packed {
        logic                       op;
        logic [`CACHE_INDEX_W-1:0]  index;
        logic [`CACHE_TAG_W-1:0]    tag;
        logic [`CACHE_OFFSET_W-1:0] offset;
        logic [3:0]                 wstrb;
        word_t                      wdata;
    } cpu_req_t;

    typedef struct packed {
        tagv_t tagv;
        line_t line;
    } way_rd_t;

    // everything the refill side needs about a miss and its victim
    typedef struct packed {
        cpu_req_t req;
        logic     way;
        tagv_t    tagv;
        logic     dirty;
        line_t    line;
    } miss_req_t;

    typedef struct packed {
        logic                      we;
        logic                      way;
        logic [`CACHE_INDEX_W-1:0] index;
        tagv_t                     tagv;
        line_t                     line;
        logic                      dirty;
    } way_wr_t;

    typedef enum logic [1:0] {LK_IDLE, LK_LOOKUP, LK_WAIT_FILL} lookup_state_t;

    typedef enum logic [1:0] {RF_IDLE, RF_MISS, RF_REPLACE, RF_REFILL} refill_state_t;

    // byte-strobe merge of a store into a word
    function automatic word_t merge_word(word_t old_word, word_t new_word, logic [3:0] strb);
        word_t res;
        res = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return res;
    endfunction

endpackage

/* rtl/cache_settings.svh */
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// set index, 256 sets
`define CACHE_INDEX_W 8

// physical tag above index and offset
`define CACHE_TAG_W 20

// byte offset inside a 16-byte line
`define CACHE_OFFSET_W 4

// 32-bit words per line
`define CACHE_WORDS 4

// victim LFSR state after reset
`define CACHE_LFSR_SEED 16'hace1

`endif
